/* hw/parc_settings.svh */
// Core-wide widths and the fetch reset vector
// Register address width must stay consistent with the register count

`ifndef PARC_SETTINGS_SVH
`define PARC_SETTINGS_SVH

// Data and address width
`define PARC_XLEN 32

// Architectural register count
`define PARC_NREGS 32

// log2 of the register count
`define PARC_REG_AW 5

// First fetch address out of reset
`define PARC_RESET_VECTOR 32'h00080000

`endif

/* hw/parc_isa_pkg.sv */
// PARCv2 instruction word layout
// One 32-bit word read as R, I or J format, all views overlay the same bits

`include "parc_settings.svh"

package parc_isa_pkg;

  // Register index
  typedef logic [`PARC_REG_AW-1:0] reg_addr_t;

  // Instruction word, three overlaid decodings
  typedef union packed {
    // Register format
    struct packed {
      logic [5:0] opcode;
      reg_addr_t  rs;
      reg_addr_t  rt;
      reg_addr_t  rd;
      logic [4:0] shamt;
      logic [5:0] func;
    } r;
    // Immediate format
    struct packed {
      logic [5:0]  opcode;
      reg_addr_t   rs;
      reg_addr_t   rt;
      logic [15:0] imm;
    } i;
    // Jump format, target in the low 26 bits
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] target;
    } j;
  } inst_t;

endpackage

/* hw/parc_dpath_pkg.sv */
// Control encodings driven from the control unit into the datapath
// Values must match the control unit tables exactly

package parc_dpath_pkg;

  // Next PC source
  typedef enum logic [1:0] {
    pc_sel_plus4   = 2'd0,
    pc_sel_branch  = 2'd1,
    pc_sel_jump    = 2'd2,
    pc_sel_jumpreg = 2'd3
  } pc_sel_t;

  // ALU operand 0 source
  typedef enum logic [1:0] {
    op0_rs      = 2'd0,
    op0_shamt   = 2'd1,
    op0_const16 = 2'd2,
    op0_const0  = 2'd3
  } op0_sel_t;

  // ALU operand 1 source, codes 5 to 7 unused
  typedef enum logic [2:0] {
    op1_rt       = 3'd0,
    op1_imm_zext = 3'd1,
    op1_imm_sext = 3'd2,
    op1_pc_plus4 = 3'd3,
    op1_const0   = 3'd4
  } op1_sel_t;

  // Bypass source for rs and rt
  typedef enum logic [1:0] {
    byp_rf = 2'd0,
    byp_x  = 2'd1,
    byp_m  = 2'd2,
    byp_w  = 2'd3
  } byp_sel_t;

  // ALU function
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_or   = 4'd3,
    alu_slt  = 4'd4,
    alu_sltu = 4'd5,
    alu_and  = 4'd6,
    alu_xor  = 4'd7,
    alu_nor  = 4'd8,
    alu_srl  = 4'd9,
    alu_sra  = 4'd10
  } alu_fn_t;

  // Load size and extension
  typedef enum logic [2:0] {
    ld_lw  = 3'd0,
    ld_lb  = 3'd1,
    ld_lbu = 3'd2,
    ld_lh  = 3'd3,
    ld_lhu = 3'd4
  } load_sel_t;

  // Writeback source
  typedef enum logic {
    wb_alu = 1'b0,
    wb_mem = 1'b1
  } wb_sel_t;

endpackage

/* hw/parc_fetch_pc.sv */
// PC select and fetch stage
// imem_addr is combinational and forced to the reset vector while reset is high

`timescale 1ns/100ps
`include "parc_settings.svh"

module parc_fetch_pc (
  input  logic                    clk,
  input  logic                    reset,
  input  parc_dpath_pkg::pc_sel_t pc_sel_p,
  input  logic                    stall_f,
  input  logic [`PARC_XLEN-1:0]   branch_targ_x,
  input  logic [`PARC_XLEN-1:0]   jump_targ_d,
  input  logic [`PARC_XLEN-1:0]   jumpreg_targ_d,
  output logic [`PARC_XLEN-1:0]   imem_addr,
  output logic [`PARC_XLEN-1:0]   pc_plus4_f
);

  logic [`PARC_XLEN-1:0] pc_mux_p;
  logic [`PARC_XLEN-1:0] pc_f;

  // Next PC mux, targets arrive from D and X
  always_comb begin
    case (pc_sel_p)
      parc_dpath_pkg::pc_sel_branch:  pc_mux_p = branch_targ_x;
      parc_dpath_pkg::pc_sel_jump:    pc_mux_p = jump_targ_d;
      parc_dpath_pkg::pc_sel_jumpreg: pc_mux_p = jumpreg_targ_d;
      default:                        pc_mux_p = pc_plus4_f;
    endcase
  end

  // Request goes out a cycle before pc_f holds it
  assign imem_addr = reset ? `PARC_RESET_VECTOR : pc_mux_p;

  // F stage PC
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= `PARC_RESET_VECTOR;
    end else if (!stall_f) begin
      pc_f <= pc_mux_p;
    end
  end

  assign pc_plus4_f = pc_f + `PARC_XLEN'd4;

endmodule

/* hw/parc_decode_operands.sv */
// D stage of the datapath
// Only pc_plus4_d is registered here, the rest is combinational from inst_d

`timescale 1ns/100ps
`include "parc_settings.svh"

module parc_decode_operands (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        stall_d,
  input  logic [`PARC_XLEN-1:0]       pc_plus4_f,
  input  logic [`PARC_XLEN-1:0]       inst_d,
  input  parc_dpath_pkg::op0_sel_t    op0_sel_d,
  input  parc_dpath_pkg::op1_sel_t    op1_sel_d,
  input  parc_dpath_pkg::byp_sel_t    rs_byp_sel_d,
  input  parc_dpath_pkg::byp_sel_t    rt_byp_sel_d,
  input  logic [`PARC_XLEN-1:0]       rf_rdata0,
  input  logic [`PARC_XLEN-1:0]       rf_rdata1,
  input  logic [`PARC_XLEN-1:0]       alu_out_x,
  input  logic [`PARC_XLEN-1:0]       wb_data_m,
  input  logic [`PARC_XLEN-1:0]       wb_data_w,
  output parc_isa_pkg::reg_addr_t     rf_raddr0,
  output parc_isa_pkg::reg_addr_t     rf_raddr1,
  output logic [`PARC_XLEN-1:0]       jump_targ_d,
  output logic [`PARC_XLEN-1:0]       jumpreg_targ_d,
  output logic [`PARC_XLEN-1:0]       branch_targ_d,
  output logic [`PARC_XLEN-1:0]       op0_d,
  output logic [`PARC_XLEN-1:0]       op1_d,
  output logic [`PARC_XLEN-1:0]       wdata_d
);

  parc_isa_pkg::inst_t   inst;
  logic [`PARC_XLEN-1:0] pc_plus4_d;
  logic [`PARC_XLEN-1:0] imm_sext_d;
  logic [`PARC_XLEN-1:0] imm_zext_d;
  logic [`PARC_XLEN-1:0] shamt_d;
  logic [`PARC_XLEN-1:0] rs_byp_d;
  logic [`PARC_XLEN-1:0] rt_byp_d;

  // D <- F
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_plus4_d <= '0;
    end else if (!stall_d) begin
      pc_plus4_d <= pc_plus4_f;
    end
  end

  // ----------------------------------------------------------
  // Field decode and immediates
  // ----------------------------------------------------------

  assign inst      = inst_d;
  assign rf_raddr0 = inst.r.rs;
  assign rf_raddr1 = inst.r.rt;

  assign imm_sext_d = {{16{inst.i.imm[15]}}, inst.i.imm};
  assign imm_zext_d = {16'b0, inst.i.imm};
  assign shamt_d    = {27'b0, inst.r.shamt};

  // Targets relative to the delay slot address
  assign branch_targ_d = pc_plus4_d + (imm_sext_d << 2);
  assign jump_targ_d   = {pc_plus4_d[31:28], inst.j.target, 2'b00};

  // ----------------------------------------------------------
  // Bypass muxes
  // ----------------------------------------------------------

  always_comb begin
    case (rs_byp_sel_d)
      parc_dpath_pkg::byp_x: rs_byp_d = alu_out_x;
      parc_dpath_pkg::byp_m: rs_byp_d = wb_data_m;
      parc_dpath_pkg::byp_w: rs_byp_d = wb_data_w;
      default:               rs_byp_d = rf_rdata0;
    endcase
  end

  always_comb begin
    case (rt_byp_sel_d)
      parc_dpath_pkg::byp_x: rt_byp_d = alu_out_x;
      parc_dpath_pkg::byp_m: rt_byp_d = wb_data_m;
      parc_dpath_pkg::byp_w: rt_byp_d = wb_data_w;
      default:               rt_byp_d = rf_rdata1;
    endcase
  end

  // jr target and store data both see forwarded values
  assign jumpreg_targ_d = rs_byp_d;
  assign wdata_d        = rt_byp_d;

  // ----------------------------------------------------------
  // Operand muxes
  // ----------------------------------------------------------

  always_comb begin
    case (op0_sel_d)
      parc_dpath_pkg::op0_shamt:   op0_d = shamt_d;
      parc_dpath_pkg::op0_const16: op0_d = `PARC_XLEN'd16;
      parc_dpath_pkg::op0_const0:  op0_d = '0;
      default:                     op0_d = rs_byp_d;
    endcase
  end

  // Unused codes fall to zero
  always_comb begin
    case (op1_sel_d)
      parc_dpath_pkg::op1_rt:       op1_d = rt_byp_d;
      parc_dpath_pkg::op1_imm_zext: op1_d = imm_zext_d;
      parc_dpath_pkg::op1_imm_sext: op1_d = imm_sext_d;
      parc_dpath_pkg::op1_pc_plus4: op1_d = pc_plus4_d;
      default:                      op1_d = '0;
    endcase
  end

endmodule

/* hw/parc_regfile.sv */
// Two read, one write register file
// Reads are combinational with no write-through, register zero reads as zero

`timescale 1ns/100ps
`include "parc_settings.svh"

module parc_regfile (
  input  logic                    clk,
  input  parc_isa_pkg::reg_addr_t raddr0,
  input  parc_isa_pkg::reg_addr_t raddr1,
  input  parc_isa_pkg::reg_addr_t waddr_w,
  input  logic                    wen_w,
  input  logic [`PARC_XLEN-1:0]   wdata_w,
  output logic [`PARC_XLEN-1:0]   rdata0,
  output logic [`PARC_XLEN-1:0]   rdata1
);

  logic [`PARC_XLEN-1:0] regs [0:`PARC_NREGS-1];

  // Writes to register zero dropped
  always_ff @(posedge clk) begin
    if (wen_w && (waddr_w != '0)) begin
      regs[waddr_w] <= wdata_w;
    end
  end

  // Entry zero never written so mask it on read
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

/* hw/parc_execute_alu.sv */
// X stage with ALU, branch flags and data memory request
// Shifts take the amount from op0[4:0] and shift op1

`timescale 1ns/100ps
`include "parc_settings.svh"

module parc_execute_alu (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall_x,
  input  parc_dpath_pkg::alu_fn_t alu_fn_x,
  input  logic [`PARC_XLEN-1:0]   op0_d,
  input  logic [`PARC_XLEN-1:0]   op1_d,
  input  logic [`PARC_XLEN-1:0]   wdata_d,
  input  logic [`PARC_XLEN-1:0]   branch_targ_d,
  output logic [`PARC_XLEN-1:0]   alu_out_x,
  output logic [`PARC_XLEN-1:0]   branch_targ_x,
  output logic [`PARC_XLEN-1:0]   dmem_addr,
  output logic [`PARC_XLEN-1:0]   dmem_wdata,
  output logic                    branch_cond_eq_x,
  output logic                    branch_cond_zero_x,
  output logic                    branch_cond_neg_x
);

  logic [`PARC_XLEN-1:0] op0_x;
  logic [`PARC_XLEN-1:0] op1_x;
  logic [`PARC_XLEN-1:0] wdata_x;
  logic [4:0]            shamt_x;

  // X <- D
  always_ff @(posedge clk) begin
    if (reset) begin
      op0_x         <= '0;
      op1_x         <= '0;
      wdata_x       <= '0;
      branch_targ_x <= '0;
    end else if (!stall_x) begin
      op0_x         <= op0_d;
      op1_x         <= op1_d;
      wdata_x       <= wdata_d;
      branch_targ_x <= branch_targ_d;
    end
  end

  assign shamt_x = op0_x[4:0];

  // ----------------------------------------------------------
  // ALU
  // ----------------------------------------------------------

  always_comb begin
    case (alu_fn_x)
      parc_dpath_pkg::alu_add:  alu_out_x = op0_x + op1_x;
      parc_dpath_pkg::alu_sub:  alu_out_x = op0_x - op1_x;
      parc_dpath_pkg::alu_sll:  alu_out_x = op1_x << shamt_x;
      parc_dpath_pkg::alu_or:   alu_out_x = op0_x | op1_x;
      parc_dpath_pkg::alu_slt:
        alu_out_x = {31'b0, $signed(op0_x) < $signed(op1_x)};
      parc_dpath_pkg::alu_sltu: alu_out_x = {31'b0, op0_x < op1_x};
      parc_dpath_pkg::alu_and:  alu_out_x = op0_x & op1_x;
      parc_dpath_pkg::alu_xor:  alu_out_x = op0_x ^ op1_x;
      parc_dpath_pkg::alu_nor:  alu_out_x = ~(op0_x | op1_x);
      parc_dpath_pkg::alu_srl:  alu_out_x = op1_x >> shamt_x;
      // Arithmetic shift keeps op1 sign
      parc_dpath_pkg::alu_sra:  alu_out_x = $unsigned($signed(op1_x) >>> shamt_x);
      default:                  alu_out_x = '0;
    endcase
  end

  // Branch condition flags for the control unit
  assign branch_cond_eq_x   = (alu_out_x == '0);
  assign branch_cond_zero_x = (op0_x == '0);
  assign branch_cond_neg_x  = op0_x[31];

  // Memory request leaves in X, response expected in M
  assign dmem_addr  = alu_out_x;
  assign dmem_wdata = wdata_x;

endmodule

/* hw/parc_mem_writeback.sv */
// M and W stages with load adjustment and writeback select
// dmem_resp_data must be valid in the same cycle the access sits in M

`timescale 1ns/100ps
`include "parc_settings.svh"

module parc_mem_writeback (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stall_m,
  input  logic                      stall_w,
  input  logic [`PARC_XLEN-1:0]     alu_out_x,
  input  logic [`PARC_XLEN-1:0]     dmem_resp_data,
  input  parc_dpath_pkg::load_sel_t load_sel_m,
  input  parc_dpath_pkg::wb_sel_t   wb_sel_m,
  output logic [`PARC_XLEN-1:0]     wb_data_m,
  output logic [`PARC_XLEN-1:0]     wb_data_w
);

  logic [`PARC_XLEN-1:0] alu_out_m;
  logic [`PARC_XLEN-1:0] load_data_m;

  // M <- X
  always_ff @(posedge clk) begin
    if (reset) begin
      alu_out_m <= '0;
    end else if (!stall_m) begin
      alu_out_m <= alu_out_x;
    end
  end

  // Subword extract from the low lanes
  always_comb begin
    case (load_sel_m)
      parc_dpath_pkg::ld_lb:  load_data_m = {{24{dmem_resp_data[7]}}, dmem_resp_data[7:0]};
      parc_dpath_pkg::ld_lbu: load_data_m = {24'b0, dmem_resp_data[7:0]};
      parc_dpath_pkg::ld_lh:  load_data_m = {{16{dmem_resp_data[15]}}, dmem_resp_data[15:0]};
      parc_dpath_pkg::ld_lhu: load_data_m = {16'b0, dmem_resp_data[15:0]};
      default:                load_data_m = dmem_resp_data;
    endcase
  end

  // Writeback select, also the M bypass value
  assign wb_data_m = (wb_sel_m == parc_dpath_pkg::wb_mem) ? load_data_m : alu_out_m;

  // W <- M
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_data_w <= '0;
    end else if (!stall_w) begin
      wb_data_w <= wb_data_m;
    end
  end

endmodule

/* hw/parc_dpath_top.sv */
// Five-stage PARCv2 datapath without the multiplier
// All selects, stalls and register write controls come from an external control unit

`timescale 1ns/100ps
`include "parc_settings.svh"

module parc_dpath_top (
  input  logic                      clk,
  input  logic                      reset,
  // Fetch controls
  input  parc_dpath_pkg::pc_sel_t   pc_sel_p,
  input  logic                      stall_f,
  // Decode controls and instruction
  input  logic                      stall_d,
  input  logic [`PARC_XLEN-1:0]     inst_d,
  input  parc_dpath_pkg::op0_sel_t  op0_sel_d,
  input  parc_dpath_pkg::op1_sel_t  op1_sel_d,
  input  parc_dpath_pkg::byp_sel_t  rs_byp_sel_d,
  input  parc_dpath_pkg::byp_sel_t  rt_byp_sel_d,
  // Execute controls
  input  logic                      stall_x,
  input  parc_dpath_pkg::alu_fn_t   alu_fn_x,
  // Memory and writeback controls
  input  logic                      stall_m,
  input  logic                      stall_w,
  input  logic [`PARC_XLEN-1:0]     dmem_resp_data,
  input  parc_dpath_pkg::load_sel_t load_sel_m,
  input  parc_dpath_pkg::wb_sel_t   wb_sel_m,
  input  logic                      rf_wen_w,
  input  parc_isa_pkg::reg_addr_t   rf_waddr_w,
  // Outputs
  output logic [`PARC_XLEN-1:0]     imem_addr,
  output logic [`PARC_XLEN-1:0]     dmem_addr,
  output logic [`PARC_XLEN-1:0]     dmem_wdata,
  output logic                      branch_cond_eq_x,
  output logic                      branch_cond_zero_x,
  output logic                      branch_cond_neg_x,
  output logic [`PARC_XLEN-1:0]     wb_data_w
);

  logic [`PARC_XLEN-1:0]   pc_plus4_f;
  logic [`PARC_XLEN-1:0]   jump_targ_d;
  logic [`PARC_XLEN-1:0]   jumpreg_targ_d;
  logic [`PARC_XLEN-1:0]   branch_targ_d;
  logic [`PARC_XLEN-1:0]   branch_targ_x;
  logic [`PARC_XLEN-1:0]   op0_d;
  logic [`PARC_XLEN-1:0]   op1_d;
  logic [`PARC_XLEN-1:0]   wdata_d;
  logic [`PARC_XLEN-1:0]   alu_out_x;
  logic [`PARC_XLEN-1:0]   wb_data_m;
  logic [`PARC_XLEN-1:0]   rf_rdata0;
  logic [`PARC_XLEN-1:0]   rf_rdata1;
  parc_isa_pkg::reg_addr_t rf_raddr0;
  parc_isa_pkg::reg_addr_t rf_raddr1;

  // ----------------------------------------------------------
  // Stages
  // ----------------------------------------------------------

  parc_fetch_pc u_fetch (
    .clk            (clk),
    .reset          (reset),
    .pc_sel_p       (pc_sel_p),
    .stall_f        (stall_f),
    .branch_targ_x  (branch_targ_x),
    .jump_targ_d    (jump_targ_d),
    .jumpreg_targ_d (jumpreg_targ_d),
    .imem_addr      (imem_addr),
    .pc_plus4_f     (pc_plus4_f)
  );

  parc_decode_operands u_decode (
    .clk            (clk),
    .reset          (reset),
    .stall_d        (stall_d),
    .pc_plus4_f     (pc_plus4_f),
    .inst_d         (inst_d),
    .op0_sel_d      (op0_sel_d),
    .op1_sel_d      (op1_sel_d),
    .rs_byp_sel_d   (rs_byp_sel_d),
    .rt_byp_sel_d   (rt_byp_sel_d),
    .rf_rdata0      (rf_rdata0),
    .rf_rdata1      (rf_rdata1),
    .alu_out_x      (alu_out_x),
    .wb_data_m      (wb_data_m),
    .wb_data_w      (wb_data_w),
    .rf_raddr0      (rf_raddr0),
    .rf_raddr1      (rf_raddr1),
    .jump_targ_d    (jump_targ_d),
    .jumpreg_targ_d (jumpreg_targ_d),
    .branch_targ_d  (branch_targ_d),
    .op0_d          (op0_d),
    .op1_d          (op1_d),
    .wdata_d        (wdata_d)
  );

  // Write port fed from the W register
  parc_regfile u_regfile (
    .clk     (clk),
    .raddr0  (rf_raddr0),
    .raddr1  (rf_raddr1),
    .waddr_w (rf_waddr_w),
    .wen_w   (rf_wen_w),
    .wdata_w (wb_data_w),
    .rdata0  (rf_rdata0),
    .rdata1  (rf_rdata1)
  );

  parc_execute_alu u_execute (
    .clk                (clk),
    .reset              (reset),
    .stall_x            (stall_x),
    .alu_fn_x           (alu_fn_x),
    .op0_d              (op0_d),
    .op1_d              (op1_d),
    .wdata_d            (wdata_d),
    .branch_targ_d      (branch_targ_d),
    .alu_out_x          (alu_out_x),
    .branch_targ_x      (branch_targ_x),
    .dmem_addr          (dmem_addr),
    .dmem_wdata         (dmem_wdata),
    .branch_cond_eq_x   (branch_cond_eq_x),
    .branch_cond_zero_x (branch_cond_zero_x),
    .branch_cond_neg_x  (branch_cond_neg_x)
  );

  parc_mem_writeback u_mem_wb (
    .clk            (clk),
    .reset          (reset),
    .stall_m        (stall_m),
    .stall_w        (stall_w),
    .alu_out_x      (alu_out_x),
    .dmem_resp_data (dmem_resp_data),
    .load_sel_m     (load_sel_m),
    .wb_sel_m       (wb_sel_m),
    .wb_data_m      (wb_data_m),
    .wb_data_w      (wb_data_w)
  );

endmodule

/* testbench/parc_dpath_assertions.sv */
// Protocol checks on the datapath top level
// Attached by bind, no ports beyond observed signals

`timescale 1ns/100ps
`include "parc_settings.svh"

module parc_dpath_assertions (
  input logic        clk,
  input logic        reset,
  input logic        stall_w,
  input logic [31:0] imem_addr,
  input logic [31:0] wb_data_w,
  input logic        branch_cond_neg_x,
  input logic        branch_cond_zero_x
);

  // Fetch starts from the reset vector
  a_reset_vector: assert property (@(posedge clk) reset |-> imem_addr == `PARC_RESET_VECTOR)
    else $error("imem_addr not at reset vector during reset");

  // W register holds while stalled
  a_stall_w_hold: assert property (@(posedge clk) disable iff (reset)
    stall_w |=> $stable(wb_data_w))
    else $error("wb_data_w changed under stall_w");

  // Zero and negative exclude each other
  a_flags_excl: assert property (@(posedge clk) !(branch_cond_neg_x && branch_cond_zero_x))
    else $error("branch_cond_neg_x and branch_cond_zero_x both high");

endmodule

bind parc_dpath_top parc_dpath_assertions u_assertions (
  .clk                (clk),
  .reset              (reset),
  .stall_w            (stall_w),
  .imem_addr          (imem_addr),
  .wb_data_w          (wb_data_w),
  .branch_cond_neg_x  (branch_cond_neg_x),
  .branch_cond_zero_x (branch_cond_zero_x)
);

/* testbench/tb_parc_dpath.sv */
// Directed testbench for the PARCv2 datapath without control unit
// Stalls stay low except in the fetch and writeback hold checks

`timescale 1ns/100ps
`include "parc_settings.svh"

module tb_parc_dpath;

  logic                      clk;
  logic                      reset;
  parc_dpath_pkg::pc_sel_t   pc_sel_p;
  logic                      stall_f;
  logic                      stall_d;
  logic [31:0]               inst_d;
  parc_dpath_pkg::op0_sel_t  op0_sel_d;
  parc_dpath_pkg::op1_sel_t  op1_sel_d;
  parc_dpath_pkg::byp_sel_t  rs_byp_sel_d;
  parc_dpath_pkg::byp_sel_t  rt_byp_sel_d;
  logic                      stall_x;
  parc_dpath_pkg::alu_fn_t   alu_fn_x;
  logic                      stall_m;
  logic                      stall_w;
  logic [31:0]               dmem_resp_data;
  parc_dpath_pkg::load_sel_t load_sel_m;
  parc_dpath_pkg::wb_sel_t   wb_sel_m;
  logic                      rf_wen_w;
  parc_isa_pkg::reg_addr_t   rf_waddr_w;
  logic [31:0]               imem_addr;
  logic [31:0]               dmem_addr;
  logic [31:0]               dmem_wdata;
  logic                      branch_cond_eq_x;
  logic                      branch_cond_zero_x;
  logic                      branch_cond_neg_x;
  logic [31:0]               wb_data_w;

  // Scoreboard and reference state
  int          errors;
  int          checks;
  logic [31:0] rng_state;
  logic [31:0] model_pc_f;
  logic [31:0] model_pc4_d;

  parc_dpath_top UUT (.*);

  always #20 clk = ~clk;

  // Stop a run that never reaches the end
  initial begin
    #400000;
    $display("Timeout, the test sequence did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // ALU rules, amount from op0[4:0], value from op1
  function automatic logic [31:0] alu_model(input int fn, input logic [31:0] a,
                                            input logic [31:0] b);
    case (fn)
      0:  return a + b;
      1:  return a - b;
      2:  return b << a[4:0];
      3:  return a | b;
      4:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      5:  return (a < b) ? 32'd1 : 32'd0;
      6:  return a & b;
      7:  return a ^ b;
      8:  return ~(a | b);
      9:  return b >> a[4:0];
      default: return $unsigned($signed(b) >>> a[4:0]);
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Outputs settle shortly after the falling edge drive
  task automatic settle();
    #1;
  endtask

  // One clock, tracking the PC registers for the fetch model
  task automatic advance_clock();
    logic [31:0] next_pc;
    settle();
    next_pc = imem_addr;
    @(posedge clk);
    if (reset) begin
      model_pc_f  = `PARC_RESET_VECTOR;
      model_pc4_d = '0;
    end else begin
      if (!stall_d) model_pc4_d = model_pc_f + 32'd4;
      if (!stall_f) model_pc_f = next_pc;
    end
    @(negedge clk);
  endtask

  task automatic drive_decode(input logic [31:0] inst, input parc_dpath_pkg::op0_sel_t s0,
                              input parc_dpath_pkg::op1_sel_t s1,
                              input parc_dpath_pkg::byp_sel_t rs_byp);
    inst_d       = inst;
    op0_sel_d    = s0;
    op1_sel_d    = s1;
    rs_byp_sel_d = rs_byp;
  endtask

  // Immediate add that produces sext16(v) in X
  function automatic logic [31:0] addi_inst(input logic [15:0] v);
    return {6'h09, 5'd0, 5'd0, v};
  endfunction

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------

  task automatic test_fetch();
    logic [31:0] held;
    pc_sel_p = parc_dpath_pkg::pc_sel_plus4;
    repeat (4) begin
      settle();
      check_value("imem_addr", imem_addr, model_pc_f + 32'd4);
      advance_clock();
    end
    stall_f = 1'b1;
    held = model_pc_f + 32'd4;
    repeat (2) begin
      advance_clock();
      check_value("imem_addr", imem_addr, held);
    end
    stall_f = 1'b0;
    advance_clock();
  endtask

  task automatic test_pc_targets();
    logic [25:0] targ;
    logic [15:0] imm;
    logic [31:0] exp;
    targ = 26'(next_random());
    inst_d = {6'h02, targ};
    pc_sel_p = parc_dpath_pkg::pc_sel_jump;
    settle();
    check_value("imem_addr", imem_addr, {model_pc4_d[31:28], targ, 2'b00});
    advance_clock();
    // Branch target leaves D, selected from X a cycle later
    imm = 16'(next_random());
    inst_d = {6'h04, 5'd0, 5'd0, imm};
    pc_sel_p = parc_dpath_pkg::pc_sel_plus4;
    exp = model_pc4_d + (sext16(imm) << 2);
    advance_clock();
    pc_sel_p = parc_dpath_pkg::pc_sel_branch;
    settle();
    check_value("imem_addr", imem_addr, exp);
    advance_clock();
    pc_sel_p = parc_dpath_pkg::pc_sel_plus4;
  endtask

  task automatic test_alu();
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    parc_dpath_pkg::op0_sel_t s0;
    parc_dpath_pkg::op1_sel_t s1;
    for (int fn = 0; fn < 11; fn++) begin
      repeat (4) begin
        inst = next_random();
        case (next_random() % 3)
          0: begin
            s0 = parc_dpath_pkg::op0_shamt;
            a  = {27'b0, inst[10:6]};
          end
          1: begin
            s0 = parc_dpath_pkg::op0_const16;
            a  = 32'd16;
          end
          default: begin
            s0 = parc_dpath_pkg::op0_const0;
            a  = 32'd0;
          end
        endcase
        if (next_random() & 1) begin
          s1 = parc_dpath_pkg::op1_imm_sext;
          b  = sext16(inst[15:0]);
        end else begin
          s1 = parc_dpath_pkg::op1_imm_zext;
          b  = {16'b0, inst[15:0]};
        end
        drive_decode(inst, s0, s1, parc_dpath_pkg::byp_rf);
        advance_clock();
        alu_fn_x = parc_dpath_pkg::alu_fn_t'(fn[3:0]);
        settle();
        exp = alu_model(fn, a, b);
        check_value("dmem_addr", dmem_addr, exp);
        check_value("branch_cond_eq_x", {31'b0, branch_cond_eq_x}, {31'b0, exp == 0});
        check_value("branch_cond_zero_x", {31'b0, branch_cond_zero_x}, {31'b0, a == 0});
        check_value("branch_cond_neg_x", {31'b0, branch_cond_neg_x}, {31'b0, a[31]});
      end
    end
    alu_fn_x = parc_dpath_pkg::alu_add;
  endtask

  task automatic write_reg(input logic [4:0] r, input logic [15:0] v);
    drive_decode(addi_inst(v), parc_dpath_pkg::op0_const0, parc_dpath_pkg::op1_imm_sext,
                 parc_dpath_pkg::byp_rf);
    alu_fn_x = parc_dpath_pkg::alu_add;
    wb_sel_m = parc_dpath_pkg::wb_alu;
    repeat (3) advance_clock();
    settle();
    check_value("wb_data_w", wb_data_w, sext16(v));
    rf_wen_w   = 1'b1;
    rf_waddr_w = r;
    advance_clock();
    rf_wen_w = 1'b0;
  endtask

  task automatic test_regfile();
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [15:0] va;
    logic [15:0] vb;
    ra = 5'((next_random() % 31) + 1);
    rb = (ra == 5'd31) ? 5'd1 : ra + 5'd1;
    // Negative so the sign flag rises on read-back
    va = 16'(next_random()) | 16'h8000;
    vb = 16'(next_random());
    write_reg(ra, va);
    write_reg(rb, vb);
    write_reg(5'd0, 16'h7abc);
    // Read back, jumpreg sees the same rs in D
    drive_decode({6'h0, ra, rb, 16'h0}, parc_dpath_pkg::op0_rs, parc_dpath_pkg::op1_const0,
                 parc_dpath_pkg::byp_rf);
    pc_sel_p = parc_dpath_pkg::pc_sel_jumpreg;
    settle();
    check_value("imem_addr", imem_addr, sext16(va));
    advance_clock();
    pc_sel_p = parc_dpath_pkg::pc_sel_plus4;
    settle();
    check_value("dmem_addr", dmem_addr, sext16(va));
    check_value("dmem_wdata", dmem_wdata, sext16(vb));
    check_value("branch_cond_neg_x", {31'b0, branch_cond_neg_x}, {31'b0, va[15]});
    // Register zero
    drive_decode({6'h0, 5'd0, 5'd0, 16'h0}, parc_dpath_pkg::op0_rs,
                 parc_dpath_pkg::op1_const0, parc_dpath_pkg::byp_rf);
    advance_clock();
    check_value("dmem_addr", dmem_addr, 32'd0);
  endtask

  task automatic test_bypass();
    logic [15:0] v [0:2];
    for (int k = 1; k <= 3; k++) begin
      for (int i = 0; i < 3; i++) begin
        v[i] = 16'(next_random());
        drive_decode(addi_inst(v[i]), parc_dpath_pkg::op0_const0,
                     parc_dpath_pkg::op1_imm_sext, parc_dpath_pkg::byp_rf);
        advance_clock();
      end
      // X holds v[2], M holds v[1], W holds v[0]
      drive_decode(32'h0, parc_dpath_pkg::op0_rs, parc_dpath_pkg::op1_const0,
                   parc_dpath_pkg::byp_sel_t'(k[1:0]));
      advance_clock();
      rs_byp_sel_d = parc_dpath_pkg::byp_rf;
      check_value("dmem_addr", dmem_addr, sext16(v[3-k]));
    end
  endtask

  task automatic test_loads();
    logic [31:0] d;
    logic [31:0] exp;
    wb_sel_m = parc_dpath_pkg::wb_mem;
    for (int k = 0; k < 5; k++) begin
      d = next_random();
      dmem_resp_data = d;
      load_sel_m = parc_dpath_pkg::load_sel_t'(k[2:0]);
      case (k)
        1:       exp = {{24{d[7]}}, d[7:0]};
        2:       exp = {24'b0, d[7:0]};
        3:       exp = sext16(d[15:0]);
        4:       exp = {16'b0, d[15:0]};
        default: exp = d;
      endcase
      advance_clock();
      check_value("wb_data_w", wb_data_w, exp);
    end
    // W keeps the last load while stall_w is high
    stall_w = 1'b1;
    dmem_resp_data = ~d;
    advance_clock();
    check_value("wb_data_w", wb_data_w, exp);
    stall_w = 1'b0;
    wb_sel_m = parc_dpath_pkg::wb_alu;
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    pc_sel_p       = parc_dpath_pkg::pc_sel_plus4;
    stall_f        = 1'b0;
    stall_d        = 1'b0;
    inst_d         = '0;
    op0_sel_d      = parc_dpath_pkg::op0_const0;
    op1_sel_d      = parc_dpath_pkg::op1_const0;
    rs_byp_sel_d   = parc_dpath_pkg::byp_rf;
    rt_byp_sel_d   = parc_dpath_pkg::byp_rf;
    stall_x        = 1'b0;
    alu_fn_x       = parc_dpath_pkg::alu_add;
    stall_m        = 1'b0;
    stall_w        = 1'b0;
    dmem_resp_data = '0;
    load_sel_m     = parc_dpath_pkg::ld_lw;
    wb_sel_m       = parc_dpath_pkg::wb_alu;
    rf_wen_w       = 1'b0;
    rf_waddr_w     = '0;
    errors         = 0;
    checks         = 0;
    rng_state      = 32'h6ae6ba2d;
    model_pc_f     = `PARC_RESET_VECTOR;
    model_pc4_d    = '0;

    settle();
    check_value("imem_addr", imem_addr, `PARC_RESET_VECTOR);
    repeat (2) advance_clock();
    check_value("wb_data_w", wb_data_w, 32'd0);
    check_value("branch_cond_zero_x", {31'b0, branch_cond_zero_x}, 32'd1);
    reset = 1'b0;

    test_fetch();
    test_pc_targets();
    test_alu();
    test_regfile();
    test_bypass();
    test_loads();

    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+hw
hw/parc_isa_pkg.sv
hw/parc_dpath_pkg.sv
hw/parc_fetch_pc.sv
hw/parc_decode_operands.sv
hw/parc_regfile.sv
hw/parc_execute_alu.sv
hw/parc_mem_writeback.sv
hw/parc_dpath_top.sv
testbench/parc_dpath_assertions.sv
testbench/tb_parc_dpath.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
  --top-module tb_parc_dpath -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
